// ==== hdl/invaders_pkg.sv ====
`default_nettype none

package invaders_pkg;

	typedef enum logic [1:0] {
		START = 2'd0,
		PLAY  = 2'd1,
		WIN   = 2'd2,
		LOSE  = 2'd3
	} game_state_t;

	typedef logic [9:0] coord_t;
	typedef logic [7:0] rgb_t;

	// index = row * ALIEN_COLS + column
	localparam int ALIEN_COLS  = 5;
	localparam int ALIEN_ROWS  = 3;
	localparam int NUM_ALIENS  = ALIEN_COLS * ALIEN_ROWS;
	localparam int ALIEN_X0    = 176;
	localparam int ALIEN_Y0    = 63;
	localparam int ALIEN_PITCH = 64;
	localparam int ALIEN_W     = 32;
	localparam int ALIEN_H     = 24;

	localparam coord_t SHIP_Y     = 10'd426;
	localparam coord_t SHIP_X0    = 10'd303;
	localparam coord_t SHIP_X_MIN = 10'd0;
	localparam coord_t SHIP_X_MAX = 10'd607;
	localparam int     SHIP_W     = 32;
	localparam int     SHIP_H     = 16;

	localparam int SHOT_W      = 4;
	localparam int SHOT_H      = 4;
	localparam int SHOT_OFFSET = 14;

	localparam int STATUS_BAR_H = 31;

	localparam logic REG_MARCH  = 1'b0;
	localparam logic REG_STATUS = 1'b1;

	// colours as {r, g, b}
	localparam logic [23:0] COL_ALIEN = 24'h00ff00;
	localparam logic [23:0] COL_SHIP  = 24'hffe1b8;
	localparam logic [23:0] COL_SHOT  = 24'hffffff;
	localparam logic [23:0] COL_BG    = 24'h000000;
	localparam logic [23:0] COL_WIN   = 24'h00ff00;
	localparam logic [23:0] COL_LOSE  = 24'h0000ff;
	localparam logic [23:0] COL_START = 24'h404040;

	function automatic int alien_x(input int idx);
		return ALIEN_X0 + (idx % ALIEN_COLS) * ALIEN_PITCH;
	endfunction

	// top edge before any march offset
	function automatic int alien_y(input int idx);
		return ALIEN_Y0 + (idx / ALIEN_COLS) * ALIEN_PITCH;
	endfunction

	function automatic logic in_box(input int px, input int py, input int bx,
			input int by, input int w, input int h);
		return (px >= bx) && (px < bx + w) && (py >= by) && (py < by + h);
	endfunction

endpackage

`default_nettype wire

// ==== hdl/game_regs.sv ====
`timescale 1ns/1ns
`default_nettype none

module game_regs #(
	parameter int MARCH_RESET = 60
) (
	input  wire         clk,
	input  wire         rst,
	input  wire         cyc,
	input  wire         stb,
	input  wire         we,
	input  wire         adr,
	input  wire  [15:0] dat_w,
	output logic [15:0] dat_r,
	output logic        ack,
	input  wire invaders_pkg::game_state_t state,
	input  wire  [2:0]  level,
	input  wire  [invaders_pkg::NUM_ALIENS-1:0] alive,
	output logic [15:0] march_period
);

	logic        req;
	logic [3:0]  live_count;
	logic [15:0] status;

	// request not yet acked
	assign req = cyc && stb && !ack;

	always_comb begin
		live_count = '0;
		for (int i = 0; i < invaders_pkg::NUM_ALIENS; i++) begin
			live_count = live_count + 4'(alive[i]);
		end
	end

	assign status = {4'd0, live_count, 3'd0, level, state};

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			ack <= 1'b0;
			march_period <= 16'(MARCH_RESET);
		end else begin
			ack <= req;
			if (req && we && adr == invaders_pkg::REG_MARCH) begin
				march_period <= dat_w;
			end
		end
	end

	// writes to the read-only status are dropped
	always_ff @(posedge clk) begin
		if (req) begin
			dat_r <= (adr == invaders_pkg::REG_STATUS) ? status : march_period;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/game_fsm.sv ====
`timescale 1ns/1ns
`default_nettype none

module game_fsm #(
	parameter int LEVELS = 2
) (
	input  wire  clk,
	input  wire  rst,
	input  wire  left_n,
	input  wire  right_n,
	input  wire  all_dead,
	input  wire  passed,
	output invaders_pkg::game_state_t state,
	output logic [2:0] level,
	output logic round_start
);

	invaders_pkg::game_state_t state_nx;
	logic [2:0] level_nx;

	always_comb begin
		state_nx = state;
		level_nx = level;
		case (state)
			invaders_pkg::START: begin
				// both buttons together start the round
				if (!left_n && !right_n) begin
					state_nx = invaders_pkg::PLAY;
				end
			end
			invaders_pkg::PLAY: begin
				if (all_dead && int'(level) < LEVELS - 1) begin
					level_nx = level + 3'd1;
					state_nx = invaders_pkg::START;
				end else if (all_dead) begin
					state_nx = invaders_pkg::WIN;
				end else if (passed) begin
					state_nx = invaders_pkg::LOSE;
				end
			end
			default: begin
				// win and lose wait for reset
				state_nx = state;
			end
		endcase
	end

	// pulses on the edge into PLAY so grid and ship are fresh on the first PLAY cycle
	assign round_start = (state == invaders_pkg::START) && (state_nx == invaders_pkg::PLAY);

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state <= invaders_pkg::START;
			level <= 3'd0;
		end else begin
			state <= state_nx;
			level <= level_nx;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/ship_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

module ship_ctrl #(
	parameter int SHIP_STEP = 4,
	parameter int SHOT_STEP = 8
) (
	input  wire  clk,
	input  wire  rst,
	input  wire  tick,
	input  wire  left_n,
	input  wire  right_n,
	input  wire  shoot_n,
	input  wire invaders_pkg::game_state_t state,
	input  wire  round_start,
	input  wire  shot_hit,
	output invaders_pkg::coord_t ship_x,
	output invaders_pkg::coord_t shot_x,
	output invaders_pkg::coord_t shot_y,
	output logic shot_live
);

	logic step;
	logic launch;
	logic advance;
	logic off_top;
	invaders_pkg::coord_t ship_nx;

	assign step    = tick && (state == invaders_pkg::PLAY);
	assign launch  = step && !shoot_n && !shot_live;
	assign advance = step && shot_live && !shot_hit;
	assign off_top = shot_y < invaders_pkg::STATUS_BAR_H + SHOT_STEP;

	// clamp at both screen edges
	always_comb begin
		ship_nx = ship_x;
		if (!left_n && right_n) begin
			if (ship_x >= invaders_pkg::SHIP_X_MIN + SHIP_STEP) begin
				ship_nx = ship_x - 10'(SHIP_STEP);
			end else begin
				ship_nx = invaders_pkg::SHIP_X_MIN;
			end
		end else if (left_n && !right_n) begin
			if (ship_x + SHIP_STEP <= invaders_pkg::SHIP_X_MAX) begin
				ship_nx = ship_x + 10'(SHIP_STEP);
			end else begin
				ship_nx = invaders_pkg::SHIP_X_MAX;
			end
		end
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			ship_x <= invaders_pkg::SHIP_X0;
			shot_live <= 1'b0;
		end else if (round_start) begin
			ship_x <= invaders_pkg::SHIP_X0;
			shot_live <= 1'b0;
		end else begin
			if (step) begin
				ship_x <= ship_nx;
			end
			if (shot_hit || (advance && off_top)) begin
				shot_live <= 1'b0;
			end else if (launch) begin
				shot_live <= 1'b1;
			end
		end
	end

	// launch uses the ship position before this tick's move
	always_ff @(posedge clk) begin
		if (launch) begin
			shot_x <= ship_x + 10'(invaders_pkg::SHOT_OFFSET);
			shot_y <= invaders_pkg::SHIP_Y;
		end else if (advance && !off_top) begin
			shot_y <= shot_y - 10'(SHOT_STEP);
		end
	end

endmodule

`default_nettype wire

// ==== hdl/alien_grid.sv ====
`timescale 1ns/1ns
`default_nettype none

module alien_grid #(
	parameter int MARCH_STEP = 8
) (
	input  wire         clk,
	input  wire         rst,
	input  wire         tick,
	input  wire invaders_pkg::game_state_t state,
	input  wire         round_start,
	input  wire  [15:0] march_period,
	input  wire invaders_pkg::coord_t shot_x,
	input  wire invaders_pkg::coord_t shot_y,
	input  wire         shot_live,
	output logic [invaders_pkg::NUM_ALIENS-1:0] alive,
	output invaders_pkg::coord_t march_offset,
	output logic        all_dead,
	output logic        passed,
	output logic        shot_hit
);

	localparam int N = invaders_pkg::NUM_ALIENS;

	logic [N-1:0] overlap;
	logic [N-1:0] first_hit;
	logic [N-1:0] low_edge;
	logic [15:0]  tick_cnt;
	logic         march_tick;
	logic         march_due;

	// shot corner against alien boxes grown by the shot size
	always_comb begin
		overlap  = '0;
		low_edge = '0;
		for (int i = 0; i < N; i++) begin
			overlap[i] = alive[i] && shot_live && invaders_pkg::in_box(shot_x, shot_y,
				invaders_pkg::alien_x(i) - invaders_pkg::SHOT_W + 1,
				invaders_pkg::alien_y(i) + int'(march_offset) - invaders_pkg::SHOT_H + 1,
				invaders_pkg::ALIEN_W + invaders_pkg::SHOT_W - 1,
				invaders_pkg::ALIEN_H + invaders_pkg::SHOT_H - 1);
			low_edge[i] = alive[i] && (invaders_pkg::alien_y(i) + int'(march_offset)
				+ invaders_pkg::ALIEN_H >= int'(invaders_pkg::SHIP_Y));
		end
	end

	// lowest index wins when the shot touches two aliens
	assign first_hit = overlap & (~overlap + 1'b1);
	assign shot_hit  = |overlap;
	assign passed    = |low_edge;
	assign all_dead  = ~|alive;

	// period 0 never marches
	assign march_tick = tick && (state == invaders_pkg::PLAY) && (march_period != 16'd0);
	assign march_due  = tick_cnt + 1 >= march_period;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			alive <= '1;
			march_offset <= '0;
			tick_cnt <= '0;
		end else if (round_start) begin
			alive <= '1;
			march_offset <= '0;
			tick_cnt <= '0;
		end else begin
			alive <= alive & ~first_hit;
			if (march_tick && march_due) begin
				tick_cnt <= '0;
				march_offset <= march_offset + 10'(MARCH_STEP);
			end else if (march_tick) begin
				tick_cnt <= tick_cnt + 16'd1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== hdl/pixel_renderer.sv ====
`timescale 1ns/1ns
`default_nettype none

module pixel_renderer (
	input  wire  clk,
	input  wire  rst,
	input  wire invaders_pkg::coord_t scan_x,
	input  wire invaders_pkg::coord_t scan_y,
	input  wire invaders_pkg::game_state_t state,
	input  wire  [invaders_pkg::NUM_ALIENS-1:0] alive,
	input  wire invaders_pkg::coord_t march_offset,
	input  wire invaders_pkg::coord_t ship_x,
	input  wire invaders_pkg::coord_t shot_x,
	input  wire invaders_pkg::coord_t shot_y,
	input  wire  shot_live,
	output invaders_pkg::rgb_t r,
	output invaders_pkg::rgb_t g,
	output invaders_pkg::rgb_t b
);

	logic        alien_px;
	logic        ship_px;
	logic        shot_px;
	logic        band_px;
	logic [23:0] pix;

	always_comb begin
		alien_px = 1'b0;
		for (int i = 0; i < invaders_pkg::NUM_ALIENS; i++) begin
			alien_px = alien_px | (alive[i] && invaders_pkg::in_box(scan_x, scan_y,
				invaders_pkg::alien_x(i),
				invaders_pkg::alien_y(i) + int'(march_offset),
				invaders_pkg::ALIEN_W, invaders_pkg::ALIEN_H));
		end
	end

	assign band_px = scan_y < invaders_pkg::STATUS_BAR_H;
	assign ship_px = invaders_pkg::in_box(scan_x, scan_y, ship_x, invaders_pkg::SHIP_Y,
		invaders_pkg::SHIP_W, invaders_pkg::SHIP_H);
	assign shot_px = shot_live && invaders_pkg::in_box(scan_x, scan_y, shot_x, shot_y,
		invaders_pkg::SHOT_W, invaders_pkg::SHOT_H);

	always_comb begin
		case (state)
			invaders_pkg::START: pix = invaders_pkg::COL_START;
			invaders_pkg::WIN:   pix = invaders_pkg::COL_WIN;
			invaders_pkg::LOSE:  pix = invaders_pkg::COL_LOSE;
			default: begin
				// top band stays black over everything
				if (band_px) begin
					pix = invaders_pkg::COL_BG;
				end else if (alien_px) begin
					pix = invaders_pkg::COL_ALIEN;
				end else if (ship_px) begin
					pix = invaders_pkg::COL_SHIP;
				end else if (shot_px) begin
					pix = invaders_pkg::COL_SHOT;
				end else begin
					pix = invaders_pkg::COL_BG;
				end
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			r <= '0;
			g <= '0;
			b <= '0;
		end else begin
			r <= pix[23:16];
			g <= pix[15:8];
			b <= pix[7:0];
		end
	end

endmodule

`default_nettype wire

// ==== hdl/space_invaders.sv ====
`timescale 1ns/1ns
`default_nettype none

module space_invaders #(
	parameter int SHIP_STEP   = 4,
	parameter int SHOT_STEP   = 8,
	parameter int MARCH_STEP  = 8,
	parameter int LEVELS      = 2,
	parameter int MARCH_RESET = 60
) (
	input  wire         clk,
	input  wire         rst,
	input  wire         left_n,
	input  wire         right_n,
	input  wire         shoot_n,
	input  wire         tick,
	input  wire invaders_pkg::coord_t scan_x,
	input  wire invaders_pkg::coord_t scan_y,
	output invaders_pkg::rgb_t r,
	output invaders_pkg::rgb_t g,
	output invaders_pkg::rgb_t b,
	input  wire         cyc,
	input  wire         stb,
	input  wire         we,
	input  wire         adr,
	input  wire  [15:0] dat_w,
	output logic [15:0] dat_r,
	output logic        ack
);

	wire invaders_pkg::game_state_t state;
	wire [2:0]  level;
	wire        round_start;
	wire [15:0] march_period;
	wire [invaders_pkg::NUM_ALIENS-1:0] alive;
	wire invaders_pkg::coord_t march_offset;
	wire        all_dead;
	wire        passed;
	wire        shot_hit;
	wire invaders_pkg::coord_t ship_x;
	wire invaders_pkg::coord_t shot_x;
	wire invaders_pkg::coord_t shot_y;
	wire        shot_live;

	game_regs #(.MARCH_RESET(MARCH_RESET)) regs_i (
		.clk(clk), .rst(rst), .cyc(cyc), .stb(stb), .we(we), .adr(adr),
		.dat_w(dat_w), .dat_r(dat_r), .ack(ack), .state(state), .level(level),
		.alive(alive), .march_period(march_period)
	);

	game_fsm #(.LEVELS(LEVELS)) fsm_i (
		.clk(clk), .rst(rst), .left_n(left_n), .right_n(right_n),
		.all_dead(all_dead), .passed(passed), .state(state), .level(level),
		.round_start(round_start)
	);

	ship_ctrl #(.SHIP_STEP(SHIP_STEP), .SHOT_STEP(SHOT_STEP)) ship_i (
		.clk(clk), .rst(rst), .tick(tick), .left_n(left_n), .right_n(right_n),
		.shoot_n(shoot_n), .state(state), .round_start(round_start),
		.shot_hit(shot_hit), .ship_x(ship_x), .shot_x(shot_x), .shot_y(shot_y),
		.shot_live(shot_live)
	);

	alien_grid #(.MARCH_STEP(MARCH_STEP)) grid_i (
		.clk(clk), .rst(rst), .tick(tick), .state(state), .round_start(round_start),
		.march_period(march_period), .shot_x(shot_x), .shot_y(shot_y),
		.shot_live(shot_live), .alive(alive), .march_offset(march_offset),
		.all_dead(all_dead), .passed(passed), .shot_hit(shot_hit)
	);

	pixel_renderer render_i (
		.clk(clk), .rst(rst), .scan_x(scan_x), .scan_y(scan_y), .state(state),
		.alive(alive), .march_offset(march_offset), .ship_x(ship_x),
		.shot_x(shot_x), .shot_y(shot_y), .shot_live(shot_live),
		.r(r), .g(g), .b(b)
	);

endmodule

`default_nettype wire

// ==== tests/tb_space_invaders.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_space_invaders;

	localparam string PATTERN_FILE = "tests/invaders_patterns.txt";
	localparam int    DEPTH        = 1024;
	localparam int    TICK_SPACING = 16;
	// about 1700 pattern ticks of 16 cycles each plus wide margin
	localparam int    CYCLE_LIMIT  = 200_000;

	logic        clk;
	logic        rst;
	logic        left_n;
	logic        right_n;
	logic        shoot_n;
	logic        tick;
	logic [9:0]  scan_x;
	logic [9:0]  scan_y;
	logic [7:0]  r;
	logic [7:0]  g;
	logic [7:0]  b;
	logic        cyc;
	logic        stb;
	logic        we;
	logic        adr;
	logic [15:0] dat_w;
	logic [15:0] dat_r;
	logic        ack;

	logic [31:0] patterns [0:DEPTH-1];
	int          errors;
	int          checks;
	int          cycles;

	space_invaders space_invaders_i (
		.clk(clk), .rst(rst), .left_n(left_n), .right_n(right_n), .shoot_n(shoot_n),
		.tick(tick), .scan_x(scan_x), .scan_y(scan_y), .r(r), .g(g), .b(b),
		.cyc(cyc), .stb(stb), .we(we), .adr(adr), .dat_w(dat_w), .dat_r(dat_r),
		.ack(ack)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#4 clk = ~clk;
		end
	end

	initial begin
		cycles = 0;
		while (cycles < CYCLE_LIMIT) begin
			@(posedge clk);
			cycles++;
		end
		$display("run stopped after %0d cycles, the pattern list did not finish", cycles);
		$display("%0d checks, %0d errors", checks, errors);
		$display("Errors found");
		$finish;
	end

	task automatic compare_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("CHECK FAILED at %0t ns: %s expected %h, got %h",
				$time, name, expected, actual);
		end
	endtask

	task automatic apply_reset();
		rst = 1'b0;
		repeat (10) @(negedge clk);
		rst = 1'b1;
		@(negedge clk);
	endtask

	// classic cycle held until ack
	task automatic bus_transfer(input logic write, input logic addr, input logic [15:0] wdata,
			output logic [15:0] rdata, output logic got_ack);
		int waited;
		waited = 0;
		got_ack = 1'b0;
		rdata = '0;
		cyc = 1'b1;
		stb = 1'b1;
		we = write;
		adr = addr;
		dat_w = wdata;
		while (!got_ack && waited < 4) begin
			@(negedge clk);
			waited++;
			if (ack) begin
				got_ack = 1'b1;
				rdata = dat_r;
			end
		end
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
		if (!got_ack) begin
			errors++;
			$display("no ack from the Wishbone slave within 4 cycles, address %0d", addr);
		end
	endtask

	task automatic set_buttons(input logic left, input logic right, input logic shoot);
		left_n = left;
		right_n = right;
		shoot_n = shoot;
		@(negedge clk);
	endtask

	task automatic give_ticks(input int n);
		for (int i = 0; i < n; i++) begin
			tick = 1'b1;
			@(negedge clk);
			tick = 1'b0;
			repeat (TICK_SPACING - 1) @(negedge clk);
		end
	endtask

	task automatic probe_pixel(input logic [9:0] x, input logic [9:0] y,
			input logic [31:0] rgb);
		scan_x = x;
		scan_y = y;
		// colour registered once
		@(negedge clk);
		compare_value("rgb", rgb, {8'd0, r, g, b});
	endtask

	initial begin
		logic [9:0]  pc;
		logic [31:0] cmd;
		logic [31:0] arg1;
		logic [31:0] arg2;
		logic [31:0] arg3;
		logic [15:0] rdata;
		logic        got_ack;
		logic        done;
		errors = 0;
		checks = 0;
		rst = 1'b0;
		left_n = 1'b1;
		right_n = 1'b1;
		shoot_n = 1'b1;
		tick = 1'b0;
		scan_x = '0;
		scan_y = '0;
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
		adr = 1'b0;
		dat_w = '0;
		$readmemh(PATTERN_FILE, patterns);
		@(negedge clk);
		apply_reset();
		pc = '0;
		done = 1'b0;
		while (!done) begin
			cmd = patterns[pc];
			arg1 = patterns[pc + 10'd1];
			arg2 = patterns[pc + 10'd2];
			arg3 = patterns[pc + 10'd3];
			case (cmd)
				0: done = 1'b1;
				1: bus_transfer(1'b1, arg1[0], arg2[15:0], rdata, got_ack);
				2: begin
					bus_transfer(1'b0, arg1[0], 16'd0, rdata, got_ack);
					if (got_ack) begin
						compare_value("dat_r", arg2, {16'd0, rdata});
					end
				end
				3: set_buttons(arg1[0], arg2[0], arg3[0]);
				4: give_ticks(int'(arg1));
				5: probe_pixel(arg1[9:0], arg2[9:0], arg3);
				6: apply_reset();
				default: begin
					errors++;
					$display("unknown pattern command %h at word %0d", cmd, pc);
					done = 1'b1;
				end
			endcase
			pc = pc + 10'd4;
			if (pc == 10'd0) begin
				done = 1'b1;
			end
		end
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== tests/invaders_patterns.txt ====
// columns (hex): command, arg1, arg2, arg3
// 1 write adr data, 2 read adr expect, 3 buttons left_n right_n shoot_n,
// 4 ticks n, 5 probe x y rgb, 6 reset, 0 end

// after reset
2 1 0f00 0
2 0 003c 0
5 64 64 404040
1 0 0000 0
2 0 0000 0

// both buttons start the round
3 0 0 1
3 1 1 1
2 1 0f01 0
5 13e 1ae ffe1b8
5 b4 46 00ff00

// first shot takes alien 12, second takes alien 7
3 1 1 0
4 1 0 0
3 1 1 1
4 1e 0 0
2 1 0e01 0
5 140 c8 000000
3 1 1 0
4 1 0 0
3 1 1 1
4 28 0 0
2 1 0d01 0

// five ticks left, ship at 283
3 0 1 1
4 5 0 0
3 1 1 1
5 11c 1ae ffe1b8
5 13c 1ae 000000

// march every tick, the 27th march reaches the ship row
6 0 0 0
3 0 0 1
3 1 1 1
1 0 0001 0
2 0 0001 0
4 1a 0 0
2 1 0f01 0
4 1 0 0
2 1 0f03 0
5 64 64 0000ff

// level 0, columns 2 1 0 3 4 with shoot held
6 0 0 0
1 0 0000 0
3 0 0 1
3 1 1 1
3 1 1 0
4 8c 0 0
3 0 1 1
4 10 0 0
3 1 1 0
4 8c 0 0
3 0 1 1
4 10 0 0
3 1 1 0
4 8c 0 0
3 1 0 1
4 30 0 0
3 1 1 0
4 8c 0 0
3 1 0 1
4 10 0 0
3 1 1 0
4 8c 0 0
3 1 1 1
2 1 0004 0

// level 1, same script ends in a win
3 0 0 1
3 1 1 1
2 1 0f05 0
3 1 1 0
4 8c 0 0
3 0 1 1
4 10 0 0
3 1 1 0
4 8c 0 0
3 0 1 1
4 10 0 0
3 1 1 0
4 8c 0 0
3 1 0 1
4 30 0 0
3 1 1 0
4 8c 0 0
3 1 0 1
4 10 0 0
3 1 1 0
4 8c 0 0
3 1 1 1
2 1 0006 0
5 64 64 00ff00
0 0 0 0

// ==== sources.f ====
hdl/invaders_pkg.sv
hdl/game_regs.sv
hdl/game_fsm.sv
hdl/ship_ctrl.sv
hdl/alien_grid.sv
hdl/pixel_renderer.sv
hdl/space_invaders.sv
tests/tb_space_invaders.sv

// ==== Makefile ====
SIM     = verilator
FLAGS   = --binary --timing -j 0
TOP     = tb_space_invaders
FILES   = sources.f
OBJ_DIR = obj_dir
LOG     = sim.log
PASS    = No errors

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILES) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
